// ==== alu_params.svh ====
`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

// operand and result width.
`define ALU_WIDTH 32

// pattern match geometry.
`define PATTERN_WIDTH 16
`define WINDOW_COUNT 17
`define COUNT_WIDTH 5

// the command register carries the function in its low bits.
`define FUNC_WIDTH 3

`define APB_ADDR_WIDTH 5

// byte offsets of the register map.
`define REG_OPA_OFFSET 5'h00
`define REG_OPB_OFFSET 5'h04
`define REG_CMD_OFFSET 5'h08
`define REG_RESULT_OFFSET 5'h0C
`define REG_STATUS_OFFSET 5'h10

`endif

// ==== apbPkg.sv ====
`include "alu_params.svh"

package apbPkg;

	// master to slave signals of one APB port.
	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [`APB_ADDR_WIDTH-1:0] paddr;
		logic [`ALU_WIDTH-1:0] pwdata;
	} apbReq_t;

	typedef struct packed {
		logic [`ALU_WIDTH-1:0] prdata;
		logic pready;
		logic pslverr; // only meaningful in the completing cycle.
	} apbRsp_t;

	typedef enum logic [`APB_ADDR_WIDTH-1:0] {
		REG_OPA = `REG_OPA_OFFSET,
		REG_OPB = `REG_OPB_OFFSET,
		REG_CMD = `REG_CMD_OFFSET,
		REG_RESULT = `REG_RESULT_OFFSET,
		REG_STATUS = `REG_STATUS_OFFSET
	} regAddr_e;

endpackage

// ==== aluPkg.sv ====
`include "alu_params.svh"

package aluPkg;

	typedef logic [`ALU_WIDTH-1:0] word_t;

	// bit 2 selects the inverted B operand, bits 1..0 pick the operation.
	typedef enum logic [`FUNC_WIDTH-1:0] {
		FN_AND = 3'd0,
		FN_OR = 3'd1,
		FN_ADD = 3'd2,
		FN_MATCH = 3'd3,
		FN_ANDN = 3'd4,
		FN_ORN = 3'd5,
		FN_SUB = 3'd6,
		FN_SLT = 3'd7
	} aluFunc_e;

	// one bit per window offset of the pattern in A.
	typedef logic [`WINDOW_COUNT-1:0] matchVec_t;

	typedef logic [`COUNT_WIDTH-1:0] matchCount_t;

	// field order follows bits 2..1 of the status word.
	typedef struct packed {
		logic overflow;
		logic zero;
	} aluFlags_t;

endpackage

// ==== arithLogicUnit.sv ====
`timescale 1ns/1ns
`include "alu_params.svh"

module arithLogicUnit (
	input aluPkg::word_t opA,
	input aluPkg::word_t opB,
	input aluPkg::aluFunc_e func,
	output aluPkg::word_t result,
	output logic overflow
);

	logic [`FUNC_WIDTH-1:0] fcode;
	logic invB;
	logic isAddSub;
	aluPkg::word_t bEff;
	aluPkg::word_t sum;

	assign fcode = func;
	assign invB = fcode[2];

	// inverting B and adding the same bit as carry-in gives A minus B.
	assign bEff = invB ? ~opB : opB;
	assign sum = opA + bEff + aluPkg::word_t'(invB);

	always_comb begin
		case (fcode[1:0])
			2'b00: result = opA & bEff;
			2'b01: result = opA | bEff;
			2'b10: result = sum;
			default: result = {{(`ALU_WIDTH-1){1'b0}}, sum[`ALU_WIDTH-1]}; // sign of A-B, uncorrected.
		endcase
	end

	assign isAddSub = (fcode[1:0] == 2'b10);

	// signed overflow means both addends agree in sign but the sum does not.
	assign overflow = isAddSub
		& (opA[`ALU_WIDTH-1] == bEff[`ALU_WIDTH-1])
		& (sum[`ALU_WIDTH-1] != opA[`ALU_WIDTH-1]);

endmodule

// ==== patternMatcher.sv ====
`timescale 1ns/1ns
`include "alu_params.svh"

module patternMatcher (
	input aluPkg::word_t opA,
	input aluPkg::word_t opB,
	output aluPkg::matchVec_t matchBits
);

	logic [`PATTERN_WIDTH-1:0] pattern;
	logic [`PATTERN_WIDTH-1:0] mask;

	assign pattern = opB[`PATTERN_WIDTH-1:0];
	assign mask = opB[2*`PATTERN_WIDTH-1:`PATTERN_WIDTH]; // a set bit means don't care.

	// window k lines the pattern up with A starting at bit k.
	for (genvar k = 0; k < `WINDOW_COUNT; k++) begin : gWindow
		logic [`PATTERN_WIDTH-1:0] bitOk;

		assign bitOk = ~(opA[k +: `PATTERN_WIDTH] ^ pattern) | mask;
		assign matchBits[k] = &bitOk;
	end

endmodule

// ==== matchCounter.sv ====
`timescale 1ns/1ns
`include "alu_params.svh"

module matchCounter (
	input logic clk,
	input logic rst,
	input aluPkg::matchVec_t matchBits,
	input logic load,
	output aluPkg::matchCount_t count
);

	aluPkg::matchCount_t ones;

	// population count of the window vector, at most 17.
	always_comb begin
		ones = '0;
		for (int i = 0; i < `WINDOW_COUNT; i++) begin
			ones = ones + aluPkg::matchCount_t'(matchBits[i]);
		end
	end

	// the register splits the comparator path from the adder chain.
	always_ff @(posedge clk) begin
		if (rst)
			count <= '0;
		else if (load)
			count <= ones;
	end

endmodule

// ==== aluCtrl.sv ====
`timescale 1ns/1ns
`include "alu_params.svh"

module aluCtrl (
	input logic clk,
	input logic rst,
	input apbPkg::apbReq_t bus,
	input aluPkg::word_t aluResult,
	input logic aluOverflow,
	input aluPkg::matchVec_t matchBits,
	input aluPkg::matchCount_t matchCount,
	output apbPkg::apbRsp_t rsp,
	output aluPkg::word_t opA,
	output aluPkg::word_t opB,
	output aluPkg::aluFunc_e func,
	output logic countLoad
);

	typedef enum logic [1:0] {
		IDLE,
		EXEC,
		COUNT
	} ctrlState_e;

	ctrlState_e state;
	apbPkg::regAddr_e addr;
	aluPkg::word_t resultReg;
	aluPkg::word_t rdData;
	aluPkg::word_t matchWord;
	aluPkg::aluFlags_t flags;
	logic ovfReg;
	logic busy;
	logic access;
	logic mapped;
	logic roReg;
	logic rdWait;
	logic errCond;
	logic wrOk;

	assign addr = apbPkg::regAddr_e'(bus.paddr);
	assign access = bus.psel & bus.penable;
	assign busy = (state != IDLE);

	always_comb begin
		mapped = 1'b1;
		roReg = 1'b0;
		rdData = '0;
		case (addr)
			apbPkg::REG_OPA: rdData = opA;
			apbPkg::REG_OPB: rdData = opB;
			apbPkg::REG_CMD: rdData = '0; // write-only.
			apbPkg::REG_RESULT: begin
				rdData = resultReg;
				roReg = 1'b1;
			end
			apbPkg::REG_STATUS: begin
				rdData = {{(`ALU_WIDTH-3){1'b0}}, flags.overflow, flags.zero, busy};
				roReg = 1'b1;
			end
			default: mapped = 1'b0;
		endcase
	end

	// reads of the result side stall until the operation has retired.
	assign rdWait = access & ~bus.pwrite & roReg & busy;
	assign errCond = ~mapped | (bus.pwrite & (roReg | busy));
	assign wrOk = access & bus.pwrite & ~errCond;

	assign rsp = '{prdata: rdData, pready: ~rdWait, pslverr: access & ~rdWait & errCond};

	assign flags.overflow = ovfReg;
	assign flags.zero = (resultReg == '0);

	assign matchWord = {{(`ALU_WIDTH-`COUNT_WIDTH-`WINDOW_COUNT){1'b0}}, matchCount, matchBits};
	assign countLoad = (state == EXEC) && (func == aluPkg::FN_MATCH);

	always_ff @(posedge clk) begin
		if (rst) begin
			opA <= '0;
			opB <= '0;
			func <= aluPkg::FN_AND;
			resultReg <= '0;
			ovfReg <= 1'b0;
			state <= IDLE;
		end else begin
			if (wrOk && addr == apbPkg::REG_OPA)
				opA <= bus.pwdata;
			if (wrOk && addr == apbPkg::REG_OPB)
				opB <= bus.pwdata;
			case (state)
				IDLE: begin
					if (wrOk && addr == apbPkg::REG_CMD) begin
						func <= aluPkg::aluFunc_e'(bus.pwdata[`FUNC_WIDTH-1:0]);
						state <= EXEC;
					end
				end
				EXEC: begin
					if (func == aluPkg::FN_MATCH) begin
						state <= COUNT; // counter takes its snapshot on this edge.
					end else begin
						resultReg <= aluResult;
						ovfReg <= aluOverflow;
						state <= IDLE;
					end
				end
				default: begin
					resultReg <= matchWord;
					ovfReg <= 1'b0;
					state <= IDLE;
				end
			endcase
		end
	end

endmodule

// ==== aluTop.sv ====
`timescale 1ns/1ns
`include "alu_params.svh"

module aluTop (
	input logic clk,
	input logic rst,
	input apbPkg::apbReq_t bus,
	output apbPkg::apbRsp_t rsp
);

	aluPkg::word_t opA;
	aluPkg::word_t opB;
	aluPkg::aluFunc_e func;
	aluPkg::word_t aluResult;
	logic aluOverflow;
	aluPkg::matchVec_t matchBits;
	aluPkg::matchCount_t matchCount;
	logic countLoad;

	aluCtrl u_ctrl (
		.clk(clk),
		.rst(rst),
		.bus(bus),
		.aluResult(aluResult),
		.aluOverflow(aluOverflow),
		.matchBits(matchBits),
		.matchCount(matchCount),
		.rsp(rsp),
		.opA(opA),
		.opB(opB),
		.func(func),
		.countLoad(countLoad)
	);

	arithLogicUnit u_alu (
		.opA(opA),
		.opB(opB),
		.func(func),
		.result(aluResult),
		.overflow(aluOverflow)
	);

	patternMatcher u_match (
		.opA(opA),
		.opB(opB),
		.matchBits(matchBits)
	);

	matchCounter u_count (
		.clk(clk),
		.rst(rst),
		.matchBits(matchBits),
		.load(countLoad),
		.count(matchCount)
	);

endmodule

// ==== aluTb.sv ====
`timescale 1ns/1ns
`include "alu_params.svh"

module aluTb;

	localparam int CLK_PERIOD = 40;
	localparam int RANDOM_OPS = 200;
	localparam int MATCH_OPS = 100;
	// two reset reads, five transfers per operation, eight for busy timing, nine for errors.
	localparam int PLANNED_XFERS = 2 + (RANDOM_OPS + MATCH_OPS) * 5 + 8 + 9;

	logic clk;
	logic rst;
	apbPkg::apbReq_t bus;
	apbPkg::apbRsp_t rsp;
	integer seed = 61;
	int passCount = 0;
	int failCount = 0;

	aluTop u_aluTop (
		.clk(clk),
		.rst(rst),
		.bus(bus),
		.rsp(rsp)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(PLANNED_XFERS * 10 * CLK_PERIOD);
		$display("timeout: the run did not finish within the watchdog limit");
		$display("Test failed");
		$finish;
	end

	// starts the setup phase at once, so back-to-back calls leave no idle cycle.
	task automatic busTransfer(input logic isWrite, input logic [`APB_ADDR_WIDTH-1:0] addr,
		input aluPkg::word_t wdata, output aluPkg::word_t rdata, output logic err,
		output int waits);
		bus.psel = 1'b1;
		bus.penable = 1'b0;
		bus.pwrite = isWrite;
		bus.paddr = addr;
		bus.pwdata = wdata;
		@(posedge clk);
		#2 bus.penable = 1'b1;
		waits = 0;
		@(negedge clk); // pready is stable mid-cycle.
		while (!rsp.pready) begin
			waits++;
			@(negedge clk);
		end
		rdata = rsp.prdata;
		err = rsp.pslverr;
		@(posedge clk);
		#2 bus = '0;
	endtask

	task automatic apbWrite(input logic [`APB_ADDR_WIDTH-1:0] addr, input aluPkg::word_t data,
		output logic err);
		aluPkg::word_t unused;
		int waits;
		busTransfer(1'b1, addr, data, unused, err, waits);
	endtask

	task automatic apbRead(input logic [`APB_ADDR_WIDTH-1:0] addr, output aluPkg::word_t data,
		output logic err, output int waits);
		busTransfer(1'b0, addr, '0, data, err, waits);
	endtask

	task automatic checkValue(input string name, input aluPkg::word_t expected,
		input aluPkg::word_t actual);
		assert (actual === expected) begin
			passCount++;
		end else begin
			$display("ERR %s expected %h actual %h", name, expected, actual);
			failCount++;
		end
	endtask

	function automatic aluPkg::word_t modelResult(input logic [2:0] fn, input aluPkg::word_t a,
		input aluPkg::word_t b);
		aluPkg::word_t diff;
		logic [`WINDOW_COUNT-1:0] windows;
		logic hit;
		int count;
		diff = a - b;
		windows = '0;
		count = 0;
		case (fn)
			aluPkg::FN_AND: return a & b;
			aluPkg::FN_OR: return a | b;
			aluPkg::FN_ANDN: return a & ~b;
			aluPkg::FN_ORN: return a | ~b;
			aluPkg::FN_ADD: return a + b;
			aluPkg::FN_SUB: return diff;
			aluPkg::FN_SLT: return {{(`ALU_WIDTH-1){1'b0}}, diff[`ALU_WIDTH-1]};
			default: begin
				// b holds the mask in its high half and the pattern in its low half.
				for (int k = 0; k < `WINDOW_COUNT; k++) begin
					hit = 1'b1;
					for (int i = 0; i < `PATTERN_WIDTH; i++)
						if (!b[`PATTERN_WIDTH + i] && b[i] != a[k + i])
							hit = 1'b0;
					windows[k] = hit;
					count += hit;
				end
				return {10'b0, count[`COUNT_WIDTH-1:0], windows};
			end
		endcase
	endfunction

	function automatic logic modelOverflow(input logic [2:0] fn, input aluPkg::word_t a,
		input aluPkg::word_t b);
		aluPkg::word_t sum;
		aluPkg::word_t diff;
		sum = a + b;
		diff = a - b;
		if (fn == aluPkg::FN_ADD)
			return (a[31] == b[31]) && (sum[31] != a[31]);
		if (fn == aluPkg::FN_SUB)
			return (a[31] != b[31]) && (diff[31] != a[31]);
		return 1'b0;
	endfunction

	task automatic runOp(input logic [2:0] fn, input aluPkg::word_t a, input aluPkg::word_t b);
		aluPkg::word_t expResult;
		aluPkg::word_t rdata;
		logic expOvf;
		logic err;
		int waits;
		expResult = modelResult(fn, a, b);
		expOvf = modelOverflow(fn, a, b);
		apbWrite(apbPkg::REG_OPA, a, err);
		apbWrite(apbPkg::REG_OPB, b, err);
		apbWrite(apbPkg::REG_CMD, {29'b0, fn}, err);
		checkValue("pslverr", 1'b0, err);
		apbRead(apbPkg::REG_RESULT, rdata, err, waits);
		checkValue("RESULT", expResult, rdata);
		apbRead(apbPkg::REG_STATUS, rdata, err, waits);
		checkValue("STATUS", {29'b0, expOvf, expResult == '0, 1'b0}, rdata);
	endtask

	task automatic reportTest(input string name, input int failsBefore);
		$display("%-14s finished with %0d errors", name, failCount - failsBefore);
	endtask

	initial begin
		aluPkg::word_t a;
		aluPkg::word_t b;
		aluPkg::word_t rnd;
		aluPkg::word_t rdata;
		logic [2:0] fn;
		logic err;
		int waits;
		int off;
		int mark;
		rst = 1'b1;
		bus = '0;
		repeat (3) @(posedge clk);
		#2 rst = 1'b0;

		mark = failCount;
		apbRead(apbPkg::REG_STATUS, rdata, err, waits);
		checkValue("STATUS", 32'h2, rdata);
		apbRead(apbPkg::REG_RESULT, rdata, err, waits);
		checkValue("RESULT", 32'h0, rdata);
		reportTest("reset state", mark);

		mark = failCount;
		for (int i = 0; i < RANDOM_OPS; i++) begin
			a = $random(seed);
			b = $random(seed);
			rnd = $random(seed);
			fn = rnd[2:0];
			while (fn == aluPkg::FN_MATCH) begin
				rnd = $random(seed);
				fn = rnd[2:0];
			end
			case (i)
				0: {fn, a, b} = {aluPkg::FN_ADD, 32'h7FFF_FFFF, 32'h0000_0001};
				1: {fn, a, b} = {aluPkg::FN_ADD, 32'h8000_0000, 32'h8000_0000};
				2: {fn, a, b} = {aluPkg::FN_SUB, 32'h8000_0000, 32'h0000_0001};
				3: {fn, a, b} = {aluPkg::FN_SUB, 32'h7FFF_FFFF, 32'hFFFF_FFFF};
				default: ;
			endcase
			runOp(fn, a, b);
		end
		reportTest("random ops", mark);

		mark = failCount;
		for (int i = 0; i < MATCH_OPS; i++) begin
			a = $random(seed);
			rnd = $random(seed);
			off = rnd % `WINDOW_COUNT;
			if (i == 0) begin
				b = {16'hFFFF, rnd[15:0]}; // every position is don't care.
			end else if (i % 2 == 1) begin
				rnd = $random(seed) & $random(seed) & $random(seed);
				b = {rnd[15:0], a[off +: `PATTERN_WIDTH]};
			end else begin
				b = $random(seed);
			end
			runOp(aluPkg::FN_MATCH, a, b);
		end
		reportTest("pattern match", mark);

		// busy clears at T+1, or T+2 for a match, and the read's access edge is T+2.
		mark = failCount;
		for (int i = 0; i < 2; i++) begin
			fn = (i == 0) ? aluPkg::FN_ADD : aluPkg::FN_MATCH;
			apbWrite(apbPkg::REG_OPA, $random(seed), err);
			apbWrite(apbPkg::REG_OPB, $random(seed), err);
			apbWrite(apbPkg::REG_CMD, {29'b0, fn}, err);
			apbRead(apbPkg::REG_STATUS, rdata, err, waits);
			checkValue("STATUS busy", 32'h0, rdata[0]);
			checkValue("pready wait cycles", i, waits);
		end
		reportTest("busy timing", mark);

		mark = failCount;
		apbWrite(apbPkg::REG_OPA, 32'h1234_5678, err);
		apbWrite(apbPkg::REG_OPB, 32'h0F0F_5678, err);
		apbWrite(apbPkg::REG_CMD, {29'b0, aluPkg::FN_MATCH}, err);
		apbWrite(apbPkg::REG_OPA, 32'hDEAD_BEEF, err);
		checkValue("pslverr OPA busy", 32'h1, err);
		apbRead(apbPkg::REG_OPA, rdata, err, waits);
		checkValue("OPA", 32'h1234_5678, rdata);
		apbWrite(apbPkg::REG_RESULT, 32'h1, err);
		checkValue("pslverr RESULT write", 32'h1, err);
		apbWrite(apbPkg::REG_STATUS, 32'h1, err);
		checkValue("pslverr STATUS write", 32'h1, err);
		apbRead(5'h14, rdata, err, waits);
		checkValue("pslverr 0x14 read", 32'h1, err);
		apbWrite(5'h14, 32'h1, err);
		checkValue("pslverr 0x14 write", 32'h1, err);
		reportTest("error response", mark);

		$display("checks passed: %0d, checks failed: %0d", passCount, failCount);
		if (failCount == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+.
apbPkg.sv
aluPkg.sv
arithLogicUnit.sv
patternMatcher.sv
matchCounter.sv
aluCtrl.sv
aluTop.sv
aluTb.sv

// ==== Bender.yml ====
package:
  name: apb_alu

sources:
  - include_dirs:
      - .
    files:
      - apbPkg.sv
      - aluPkg.sv
      - arithLogicUnit.sv
      - patternMatcher.sv
      - matchCounter.sv
      - aluCtrl.sv
      - aluTop.sv
  - target: test
    include_dirs:
      - .
    files:
      - aluTb.sv
